// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_xt_boot \
	-f sources.f -Mdir obj_dir -o sim_tb || exit 1
./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || exit 1
exit 0

// File: sources.f
+incdir+src
src/xt_pkg.sv
src/ioctl_if.sv
src/reset_sequencer.sv
src/clock_control.sv
src/bios_loader.sv
src/audio_mixer.sv
src/xt_boot_top.sv
testbench/tb_xt_boot.sv

// File: src/audio_mixer.sv
// module audio_mixer: opl2, speaker and tandy sound sum and first-order sigma-delta DAC
`timescale 1ns/1ps
`default_nettype none
`include "xt_consts.svh"

module audio_mixer (
	input  logic               clk_chipset,
	input  logic               reset,
	input  logic signed [15:0] opl2_snd_i,
	input  logic               speaker_i,
	input  logic [7:0]         tandy_snd_i,
	output logic               audio_o
);

	// speaker level, active when the pin is low
	localparam logic [`MIX_W-1:0] SPK_LEVEL = `MIX_W'(1 << 14);

	logic [`MIX_W-1:0] mix;
	logic [`MIX_W-1:0] spk_term;
	logic [`DAC_W-1:0] dac_in;
	logic [`DAC_W:0]   acc_q;

	////////////////////////////////////////
	// mixer
	////////////////////////////////////////

	assign spk_term = speaker_i ? '0 : SPK_LEVEL;
	// opl2 sign extended, tandy scaled up by 2^9
	assign mix      = {opl2_snd_i[15], opl2_snd_i} + spk_term + {tandy_snd_i, 9'd0};
	// drop two lsbs for headroom
	assign dac_in   = mix[`MIX_W-1:2];

	////////////////////////////////////////
	// sigma-delta DAC
	////////////////////////////////////////

	// carry out of the low bits is the bitstream
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			acc_q <= '0;
		end else begin
			acc_q <= {1'b0, acc_q[`DAC_W-1:0]} + {1'b0, dac_in};
		end
	end

	assign audio_o = acc_q[`DAC_W];

endmodule

`default_nettype wire

// File: src/bios_loader.sv
// module bios_loader: image decode, bios address map and write FSM with tandy flag
`timescale 1ns/1ps
`default_nettype none
`include "xt_consts.svh"

module bios_loader (
	input  logic                   clk_chipset,
	input  logic                   sys_reset,
	ioctl_if.loader                ioctl,
	input  logic                   sdram_ready_i,
	input  logic                   bus_idle_i,
	input  logic                   model_tandy_i,
	output logic                   bios_request_o,
	output logic                   bios_protect_o,
	output logic                   bios_write_n_o,
	output logic [`CPU_ADDR_W-1:0] bios_addr_o,
	output logic [7:0]             bios_data_o,
	output logic                   bios_tandy_flag_o
);

	xt_pkg::bios_state_e   state_q;
	xt_pkg::bios_image_e   image;
	logic [`CPU_ADDR_W-1:0] map_addr;
	logic [7:0]            wait_cnt_q;
	logic                  tandy_wr_q;
	logic                  tandy_mode_q;
	logic                  high_addr_zero;

	////////////////////////////////////////
	// image decode and address map
	////////////////////////////////////////

	// main images are at most 64k
	assign high_addr_zero = (ioctl.addr[`IOCTL_ADDR_W-1:16] == '0);

	always_comb begin
		if ((ioctl.index[5:0] < 6'd2) && high_addr_zero) begin
			image = xt_pkg::IMG_PCXT;
		end else if ((ioctl.index[5:0] == 6'd2) && high_addr_zero) begin
			image = xt_pkg::IMG_TANDY;
		end else if (ioctl.index == 8'd3) begin
			image = xt_pkg::IMG_XTIDE;
		end else begin
			image = xt_pkg::IMG_NONE;
		end
	end

	always_comb begin
		case (image)
			xt_pkg::IMG_PCXT,
			xt_pkg::IMG_TANDY: map_addr = {`BIOS_MAIN_SEG, ioctl.addr[15:0]};
			xt_pkg::IMG_XTIDE: map_addr = {`BIOS_EXT_BASE, ioctl.addr[13:0]};
			default:           map_addr = '1;
		endcase
	end

	////////////////////////////////////////
	// write FSM
	////////////////////////////////////////

	always_ff @(posedge clk_chipset or posedge sys_reset) begin
		if (sys_reset) begin
			state_q        <= xt_pkg::IDLE;
			bios_protect_o <= 1'b1;
			bios_request_o <= 1'b0;
			bios_addr_o    <= '1;
			bios_data_o    <= 8'hFF;
			bios_write_n_o <= 1'b1;
			wait_cnt_q     <= '0;
			tandy_wr_q     <= 1'b0;
		end else if (!sdram_ready_i) begin
			// memory not up yet, park everything
			state_q        <= xt_pkg::IDLE;
			bios_protect_o <= 1'b1;
			bios_request_o <= 1'b0;
			bios_addr_o    <= '1;
			bios_data_o    <= 8'hFF;
			bios_write_n_o <= 1'b1;
			wait_cnt_q     <= '0;
			tandy_wr_q     <= 1'b0;
		end else begin
			case (state_q)
				xt_pkg::IDLE: begin
					bios_protect_o <= 1'b1;
					bios_request_o <= ioctl.download;
					bios_addr_o    <= '1;
					bios_data_o    <= 8'hFF;
					bios_write_n_o <= 1'b1;
					wait_cnt_q     <= '0;
					tandy_wr_q     <= 1'b0;
					// wait for the processor to leave the bus
					if (ioctl.download && bus_idle_i) begin
						state_q <= xt_pkg::ARMED;
					end
				end
				xt_pkg::ARMED: begin
					bios_protect_o <= 1'b0;
					bios_request_o <= 1'b1;
					bios_write_n_o <= 1'b1;
					wait_cnt_q     <= '0;
					if (!ioctl.download) begin
						state_q <= xt_pkg::IDLE;
					end else if (ioctl.wr && (image != xt_pkg::IMG_NONE)) begin
						// capture byte, strobe goes low next edge
						bios_addr_o <= map_addr;
						bios_data_o <= ioctl.data;
						tandy_wr_q  <= (image == xt_pkg::IMG_TANDY);
						state_q     <= xt_pkg::WRITE;
					end
				end
				xt_pkg::WRITE: begin
					wait_cnt_q <= wait_cnt_q + 8'd1;
					if (wait_cnt_q != `BIOS_WRITE_LOW_CYCLES) begin
						bios_write_n_o <= 1'b0;
					end else begin
						bios_write_n_o <= 1'b1;
						state_q        <= xt_pkg::RECOVER;
					end
				end
				default: begin
					// recovery gap, counter keeps running from WRITE
					bios_addr_o <= '1;
					bios_data_o <= 8'hFF;
					tandy_wr_q  <= 1'b0;
					wait_cnt_q  <= wait_cnt_q + 8'd1;
					if (wait_cnt_q == `BIOS_BYTE_CYCLES - 8'd1) begin
						state_q <= xt_pkg::ARMED;
					end
				end
			endcase
		end
	end

	// board model sampled while reset is held
	always_ff @(posedge clk_chipset) begin
		if (sys_reset) begin
			tandy_mode_q <= model_tandy_i;
		end
	end

	// write bit only during the strobe
	assign bios_tandy_flag_o = bios_write_n_o ? tandy_mode_q : tandy_wr_q;

	a_write_in_state: assert property (@(posedge clk_chipset) disable iff (sys_reset)
		!bios_write_n_o |-> (state_q == xt_pkg::WRITE));

endmodule

`default_nettype wire

// File: src/clock_control.sv
// module clock_control: speed latch, clock selection, synchronizers and edge enables
`timescale 1ns/1ps
`default_nettype none

module clock_control (
	input  logic               clk_chipset,
	input  logic               reset,
	input  xt_pkg::cpu_speed_e speed_req_i,
	input  logic               biu_done_i,
	input  logic               clk_4m77_i,
	input  logic               clk_7m16_i,
	input  logic               clk_14m318_i,
	input  logic               periph_clk_i,
	input  logic               opl2_clk_i,
	input  logic               uart_clk_i,
	output logic               turbo_o,
	output logic               cpu_clk_o,
	output logic               pclk_o,
	output logic               opl2_en_o,
	output logic               uart_en_o
);

	xt_pkg::cpu_speed_e speed_q;
	logic               sel_clk;
	// bit 1 cpu clock, bit 0 peripheral clock
	logic [1:0]         clk_ff1_q;
	logic [1:0]         clk_ff2_q;
	logic [1:0]         clk_ff3_q;
	// bit 1 uart clock, bit 0 opl2 clock
	logic [1:0]         edge_ff1_q;
	logic [1:0]         edge_ff2_q;
	logic [1:0]         edge_ff3_q;
	logic [1:0]         en_q;

	////////////////////////////////////////
	// speed latch
	////////////////////////////////////////

	// only changes while the bus unit is idle
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			speed_q <= xt_pkg::SPEED_4M77;
		end else if (biu_done_i) begin
			speed_q <= speed_req_i;
		end
	end

	assign turbo_o = (speed_q == xt_pkg::SPEED_7M16) || (speed_q == xt_pkg::SPEED_14M318);

	// reserved code falls back to 4.77
	always_comb begin
		case (speed_q)
			xt_pkg::SPEED_7M16:   sel_clk = clk_7m16_i;
			xt_pkg::SPEED_14M318: sel_clk = clk_14m318_i;
			default:              sel_clk = clk_4m77_i;
		endcase
	end

	////////////////////////////////////////
	// synchronizers and enables
	////////////////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			clk_ff1_q  <= '0;
			clk_ff2_q  <= '0;
			clk_ff3_q  <= '0;
			edge_ff1_q <= '0;
			edge_ff2_q <= '0;
			edge_ff3_q <= '0;
			en_q       <= '0;
		end else begin
			clk_ff1_q  <= {sel_clk, periph_clk_i};
			clk_ff2_q  <= clk_ff1_q;
			clk_ff3_q  <= clk_ff2_q;
			edge_ff1_q <= {uart_clk_i, opl2_clk_i};
			edge_ff2_q <= edge_ff1_q;
			edge_ff3_q <= edge_ff2_q;
			// rising edge seen between stages 2 and 3
			en_q       <= edge_ff2_q & ~edge_ff3_q;
		end
	end

	assign cpu_clk_o = clk_ff3_q[1];
	assign pclk_o    = clk_ff3_q[0];
	assign opl2_en_o = en_q[0];
	assign uart_en_o = en_q[1];

	// enable is a single pulse per slow clock edge
	a_opl2_en_pulse: assert property (@(posedge clk_chipset) disable iff (reset)
		opl2_en_o |=> !opl2_en_o);

endmodule

`default_nettype wire

// File: src/ioctl_if.sv
// interface ioctl_if for the host download bus, with source and loader modports
`timescale 1ns/1ps
`default_nettype none
`include "xt_consts.svh"

interface ioctl_if;
	// download active level
	logic                     download;
	logic [7:0]               index;
	// one-cycle write strobe, no wait back to the host
	logic                     wr;
	logic [`IOCTL_ADDR_W-1:0] addr;
	logic [7:0]               data;

	modport source (output download, index, wr, addr, data);
	modport loader (input download, index, wr, addr, data);
endinterface

`default_nettype wire

// File: src/reset_sequencer.sv
// module reset_sequencer: system reset stretcher and delayed processor reset release
`timescale 1ns/1ps
`default_nettype none
`include "xt_consts.svh"

module reset_sequencer (
	input  logic clk_chipset,
	input  logic reset,
	input  logic soft_reset_i,
	output logic sys_reset_o,
	output logic cpu_reset_o
);

	logic [15:0] stretch_cnt_q;
	logic        sys_reset_d1_q;
	logic [15:0] release_cnt_q;

	////////////////////////////////////////
	// system reset stretch
	////////////////////////////////////////

	// soft request sampled on the clock, hard reset is async
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			sys_reset_o   <= 1'b1;
			stretch_cnt_q <= '0;
		end else if (soft_reset_i) begin
			sys_reset_o   <= 1'b1;
			stretch_cnt_q <= '0;
		end else if (sys_reset_o) begin
			// drops on the last counted edge
			if (stretch_cnt_q == `RESET_STRETCH_CYCLES - 16'd1) begin
				sys_reset_o <= 1'b0;
			end else begin
				stretch_cnt_q <= stretch_cnt_q + 16'd1;
			end
		end
	end

	////////////////////////////////////////
	// processor reset release
	////////////////////////////////////////

	// one flop behind the system reset
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			sys_reset_d1_q <= 1'b1;
		end else begin
			sys_reset_d1_q <= sys_reset_o;
		end
	end

	// raised with the system reset in the same edge
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			cpu_reset_o   <= 1'b1;
			release_cnt_q <= '0;
		end else if (soft_reset_i || sys_reset_o) begin
			cpu_reset_o   <= 1'b1;
			release_cnt_q <= '0;
		end else if (sys_reset_d1_q) begin
			// delayed copy still high, count starts next edge
			release_cnt_q <= '0;
		end else if (cpu_reset_o) begin
			if (release_cnt_q == `CPU_RESET_DELAY) begin
				cpu_reset_o <= 1'b0;
			end else begin
				release_cnt_q <= release_cnt_q + 16'd1;
			end
		end
	end

	// processor never leaves reset ahead of the system
	a_cpu_under_sys: assert property (@(posedge clk_chipset) disable iff (reset)
		sys_reset_o |-> cpu_reset_o);

endmodule

`default_nettype wire

// File: src/xt_boot_top.sv
// module xt_boot_top: top level with reset, clock, bios loader and audio instances
`timescale 1ns/1ps
`default_nettype none
`include "xt_consts.svh"

module xt_boot_top (
	input  logic                     clk_chipset,
	input  logic                     reset,
	input  logic                     soft_reset_i,
	// host download
	input  logic                     ioctl_download_i,
	input  logic [7:0]               ioctl_index_i,
	input  logic                     ioctl_wr_i,
	input  logic [`IOCTL_ADDR_W-1:0] ioctl_addr_i,
	input  logic [7:0]               ioctl_data_i,
	input  logic                     sdram_ready_i,
	input  logic                     bus_idle_i,
	input  logic                     model_tandy_i,
	// clocks
	input  xt_pkg::cpu_speed_e       speed_req_i,
	input  logic                     biu_done_i,
	input  logic                     clk_4m77_i,
	input  logic                     clk_7m16_i,
	input  logic                     clk_14m318_i,
	input  logic                     periph_clk_i,
	input  logic                     opl2_clk_i,
	input  logic                     uart_clk_i,
	// sound sources
	input  logic signed [15:0]       opl2_snd_i,
	input  logic                     speaker_i,
	input  logic [7:0]               tandy_snd_i,
	output logic                     sys_reset_o,
	output logic                     cpu_reset_o,
	output logic                     turbo_o,
	output logic                     cpu_clk_o,
	output logic                     pclk_o,
	output logic                     opl2_en_o,
	output logic                     uart_en_o,
	output logic                     bios_request_o,
	output logic                     bios_protect_o,
	output logic                     bios_write_n_o,
	output logic [`CPU_ADDR_W-1:0]   bios_addr_o,
	output logic [7:0]               bios_data_o,
	output logic                     bios_tandy_flag_o,
	output logic                     audio_o,
	output logic                     download_led_o
);

	ioctl_if ioctl_bus ();

	// led lit while idle
	assign download_led_o     = ~ioctl_download_i;
	assign ioctl_bus.download = ioctl_download_i;
	assign ioctl_bus.index    = ioctl_index_i;
	assign ioctl_bus.wr       = ioctl_wr_i;
	assign ioctl_bus.addr     = ioctl_addr_i;
	assign ioctl_bus.data     = ioctl_data_i;

	reset_sequencer i_reset_sequencer (
		.clk_chipset (clk_chipset), .reset (reset), .soft_reset_i (soft_reset_i),
		.sys_reset_o (sys_reset_o), .cpu_reset_o (cpu_reset_o)
	);

	clock_control i_clock_control (
		.clk_chipset (clk_chipset), .reset (reset), .speed_req_i (speed_req_i),
		.biu_done_i (biu_done_i), .clk_4m77_i (clk_4m77_i), .clk_7m16_i (clk_7m16_i),
		.clk_14m318_i (clk_14m318_i), .periph_clk_i (periph_clk_i),
		.opl2_clk_i (opl2_clk_i), .uart_clk_i (uart_clk_i), .turbo_o (turbo_o),
		.cpu_clk_o (cpu_clk_o), .pclk_o (pclk_o), .opl2_en_o (opl2_en_o),
		.uart_en_o (uart_en_o)
	);

	// loader runs under the stretched system reset
	bios_loader i_bios_loader (
		.clk_chipset (clk_chipset), .sys_reset (sys_reset_o), .ioctl (ioctl_bus.loader),
		.sdram_ready_i (sdram_ready_i), .bus_idle_i (bus_idle_i),
		.model_tandy_i (model_tandy_i), .bios_request_o (bios_request_o),
		.bios_protect_o (bios_protect_o), .bios_write_n_o (bios_write_n_o),
		.bios_addr_o (bios_addr_o), .bios_data_o (bios_data_o),
		.bios_tandy_flag_o (bios_tandy_flag_o)
	);

	audio_mixer i_audio_mixer (
		.clk_chipset (clk_chipset), .reset (reset), .opl2_snd_i (opl2_snd_i),
		.speaker_i (speaker_i), .tandy_snd_i (tandy_snd_i), .audio_o (audio_o)
	);

endmodule

`default_nettype wire

// File: src/xt_consts.svh
// reset lengths, bios write timing, bios address windows and audio widths
`ifndef XT_CONSTS_SVH
`define XT_CONSTS_SVH

////////////////////////////////////////
// reset timing
////////////////////////////////////////

// cycles of system reset after the last request
`define RESET_STRETCH_CYCLES 16'd1024
// extra cycles the processor stays in reset
`define CPU_RESET_DELAY 16'd42

////////////////////////////////////////
// bios write timing and windows
////////////////////////////////////////

// write strobe low time
`define BIOS_WRITE_LOW_CYCLES 8'd20
// capture to ready for next byte
`define BIOS_BYTE_CYCLES 8'd41
// F0000 window for pcxt and tandy images
`define BIOS_MAIN_SEG 4'hF
// EC000 window for the xt-ide image
`define BIOS_EXT_BASE 6'b111011

////////////////////////////////////////
// bus and audio widths
////////////////////////////////////////

`define IOCTL_ADDR_W 25
`define CPU_ADDR_W 20
`define DAC_W 15
`define MIX_W 17

`endif

// File: src/xt_pkg.sv
// package xt_pkg with bios loader state, cpu speed and bios image enums
`default_nettype none

package xt_pkg;

	////////////////////////////////////////
	// bios loader FSM
	////////////////////////////////////////

	// idle, armed for a byte, strobe low, recovery gap
	typedef enum logic [1:0] {
		IDLE,
		ARMED,
		WRITE,
		RECOVER
	} bios_state_e;

	// processor clock choice, reserved code runs at 4.77
	typedef enum logic [1:0] {
		SPEED_4M77   = 2'd0,
		SPEED_7M16   = 2'd1,
		SPEED_14M318 = 2'd2,
		SPEED_RSVD   = 2'd3
	} cpu_speed_e;

	// image kind decoded from the download index
	typedef enum logic [1:0] {
		IMG_NONE,
		IMG_PCXT,
		IMG_TANDY,
		IMG_XTIDE
	} bios_image_e;

endpackage

`default_nettype wire

// File: testbench/tb_xt_boot.sv
// module tb_xt_boot: testbench with clock, reset, seeded random stimulus, models and checks
`timescale 1ns/1ps
`default_nettype none
`include "xt_consts.svh"

module tb_xt_boot;

	localparam int BIOS_BYTES    = 6;
	localparam int RESET_TEST    = 2 * (8 + `RESET_STRETCH_CYCLES + `CPU_RESET_DELAY + 4);
	localparam int BIOS_TEST     = 5 * (BIOS_BYTES * 44 + 12);
	localparam int AUDIO_TEST    = 2000;
	localparam int TIMEOUT_LIMIT = 2 * (RESET_TEST + BIOS_TEST + AUDIO_TEST);

	logic clk_chipset, reset, soft_reset_i;
	logic ioctl_download_i, ioctl_wr_i;
	logic [7:0] ioctl_index_i, ioctl_data_i, tandy_snd_i;
	logic [`IOCTL_ADDR_W-1:0] ioctl_addr_i;
	logic sdram_ready_i, bus_idle_i, model_tandy_i, biu_done_i;
	xt_pkg::cpu_speed_e speed_req_i;
	logic clk_4m77_i, clk_7m16_i, clk_14m318_i, periph_clk_i, opl2_clk_i, uart_clk_i;
	logic signed [15:0] opl2_snd_i;
	logic speaker_i;
	logic sys_reset_o, cpu_reset_o, turbo_o, cpu_clk_o, pclk_o, opl2_en_o, uart_en_o;
	logic bios_request_o, bios_protect_o, bios_write_n_o, bios_tandy_flag_o;
	logic [`CPU_ADDR_W-1:0] bios_addr_o;
	logic [7:0] bios_data_o;
	logic audio_o, download_led_o;

	int errors;
	int cycle_cnt;
	// random run lengths for the slow clocks and the sound inputs
	int unsigned run_left [6];
	int unsigned snd_left;
	logic [5:0] slow_lvl;
	// model state
	xt_pkg::cpu_speed_e m_speed;
	logic m_turbo;
	logic [1:0] m_clk1, m_clk2, m_clk3;
	logic [1:0] m_edge1, m_edge2, m_edge3, m_en;
	logic [16:0] m_mix;
	logic [15:0] m_acc;

	xt_boot_top i_dut (.*);

	always #2 clk_chipset = ~clk_chipset;

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		errors++;
		$display("ERROR %0t ns %s: expected %0h, actual %0h", $time, name, exp, act);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("FAILURE %0t ns: %s", $time, what);
	endtask

	////////////////////////////////////////
	// background random stimulus
	////////////////////////////////////////

	always @(posedge clk_chipset) begin
		#1;
		for (int i = 0; i < 6; i++) begin
			if (run_left[i] == 0) begin
				slow_lvl[i] = ($urandom() & 1) != 0;
				run_left[i] = $urandom_range(8, 1) - 1;
			end else begin
				run_left[i] = run_left[i] - 1;
			end
		end
		{clk_4m77_i, clk_7m16_i, clk_14m318_i,
			periph_clk_i, opl2_clk_i, uart_clk_i} = slow_lvl;
		biu_done_i  = ($urandom() % 4) == 0;
		speed_req_i = xt_pkg::cpu_speed_e'(2'($urandom()));
		// sound held for random stretches
		if (snd_left == 0) begin
			opl2_snd_i  = 16'($urandom());
			speaker_i   = ($urandom() & 1) != 0;
			tandy_snd_i = 8'($urandom());
			snd_left    = $urandom_range(16, 1) - 1;
		end else begin
			snd_left = snd_left - 1;
		end
	end

	////////////////////////////////////////
	// reference models
	////////////////////////////////////////

	// model state advances on the same edges as the DUT
	always @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			m_speed = xt_pkg::SPEED_4M77;
			m_turbo = 1'b0;
			m_clk1  = '0;
			m_clk2  = '0;
			m_clk3  = '0;
			m_edge1 = '0;
			m_edge2 = '0;
			m_edge3 = '0;
			m_en    = '0;
			m_acc   = '0;
		end else begin
			m_clk3 = m_clk2;
			m_clk2 = m_clk1;
			// selection uses the speed held before this edge
			case (m_speed)
				xt_pkg::SPEED_7M16:   m_clk1 = {clk_7m16_i, periph_clk_i};
				xt_pkg::SPEED_14M318: m_clk1 = {clk_14m318_i, periph_clk_i};
				default:              m_clk1 = {clk_4m77_i, periph_clk_i};
			endcase
			m_en    = m_edge2 & ~m_edge3;
			m_edge3 = m_edge2;
			m_edge2 = m_edge1;
			m_edge1 = {uart_clk_i, opl2_clk_i};
			if (biu_done_i) begin
				m_speed = speed_req_i;
			end
			// turbo only for the two fast settings
			case (m_speed)
				xt_pkg::SPEED_7M16,
				xt_pkg::SPEED_14M318: m_turbo = 1'b1;
				default:              m_turbo = 1'b0;
			endcase
			m_mix = {opl2_snd_i[15], opl2_snd_i} + (speaker_i ? 17'd0 : 17'd16384)
				+ {tandy_snd_i, 9'd0};
			m_acc = {1'b0, m_acc[14:0]} + {1'b0, m_mix[16:2]};
		end
	end

	// per-cycle output compare on the falling edge
	always @(negedge clk_chipset) begin
		if (!reset) begin
			if (cpu_clk_o !== m_clk3[1]) report_mismatch("cpu_clk_o", m_clk3[1], cpu_clk_o);
			if (pclk_o !== m_clk3[0]) report_mismatch("pclk_o", m_clk3[0], pclk_o);
			if (opl2_en_o !== m_en[0]) report_mismatch("opl2_en_o", m_en[0], opl2_en_o);
			if (uart_en_o !== m_en[1]) report_mismatch("uart_en_o", m_en[1], uart_en_o);
			if (turbo_o !== m_turbo) report_mismatch("turbo_o", m_turbo, turbo_o);
			if (audio_o !== m_acc[15]) report_mismatch("audio_o", m_acc[15], audio_o);
			if (download_led_o !== !ioctl_download_i)
				report_mismatch("download_led_o", !ioctl_download_i, download_led_o);
		end
	end

	////////////////////////////////////////
	// timeout
	////////////////////////////////////////

	always @(posedge clk_chipset) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_LIMIT) begin
			$display("run did not finish within %0d cycles", TIMEOUT_LIMIT);
			$display("errors: %0d", errors + 1);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// counts edges until each reset output falls
	task automatic measure_reset_release();
		int n;
		int m;
		n = 0;
		do begin
			@(posedge clk_chipset);
			n++;
			@(negedge clk_chipset);
		end while (sys_reset_o && n < 5000);
		if (n != `RESET_STRETCH_CYCLES)
			report_mismatch("sys_reset_o cycles", `RESET_STRETCH_CYCLES, n);
		m = 0;
		do begin
			@(posedge clk_chipset);
			m++;
			@(negedge clk_chipset);
		end while (cpu_reset_o && m < 5000);
		if (m != `CPU_RESET_DELAY + 2)
			report_mismatch("cpu_reset_o cycles", `CPU_RESET_DELAY + 2, m);
	endtask

	function automatic logic [19:0] map_bios_addr(input logic [7:0] idx, input logic [24:0] a);
		if (idx == 8'd3) begin
			return {6'b111011, a[13:0]};
		end
		return {4'hF, a[15:0]};
	endfunction

	// one host write and the strobe over the whole byte slot
	task automatic send_byte(input logic [7:0] idx, input logic [24:0] a,
		input logic [7:0] d, input bit accept);
		int low_cnt;
		logic [19:0] exp_addr;
		bit tandy_img;
		low_cnt   = 0;
		exp_addr  = map_bios_addr(idx, a);
		tandy_img = (idx[5:0] == 6'd2) && (a[24:16] == 9'd0);
		@(posedge clk_chipset);
		#1;
		ioctl_wr_i   = 1'b1;
		ioctl_addr_i = a;
		ioctl_data_i = d;
		@(posedge clk_chipset);
		#1;
		ioctl_wr_i = 1'b0;
		for (int i = 0; i < 43; i++) begin
			@(negedge clk_chipset);
			if (bios_request_o !== 1'b1)
				report_mismatch("bios_request_o", 1'b1, bios_request_o);
			if (!bios_write_n_o) begin
				low_cnt++;
				if (bios_addr_o !== exp_addr)
					report_mismatch("bios_addr_o", exp_addr, bios_addr_o);
				if (bios_data_o !== d) report_mismatch("bios_data_o", d, bios_data_o);
				if (bios_tandy_flag_o !== tandy_img)
					report_mismatch("bios_tandy_flag_o", tandy_img, bios_tandy_flag_o);
			end else if (bios_tandy_flag_o !== model_tandy_i) begin
				report_mismatch("bios_tandy_flag_o", model_tandy_i, bios_tandy_flag_o);
			end
		end
		if (accept && low_cnt != `BIOS_WRITE_LOW_CYCLES)
			report_mismatch("bios_write_n_o low cycles", `BIOS_WRITE_LOW_CYCLES, low_cnt);
		if (!accept && low_cnt != 0) report_failure("write strobe seen for an unknown index");
	endtask

	task automatic run_download(input logic [7:0] idx, input bit accept);
		int t;
		logic [24:0] a;
		@(posedge clk_chipset);
		#1;
		ioctl_download_i = 1'b1;
		ioctl_index_i    = idx;
		t = 0;
		do begin
			@(negedge clk_chipset);
			t++;
		end while (bios_protect_o && t < 100);
		if (bios_protect_o) report_failure("loader never dropped protect");
		if (bios_request_o !== 1'b1) report_mismatch("bios_request_o", 1'b1, bios_request_o);
		for (int b = 0; b < BIOS_BYTES; b++) begin
			a = (idx == 8'd3) ? 25'($urandom()) : {9'd0, 16'($urandom())};
			send_byte(idx, a, 8'($urandom()), accept);
		end
		@(posedge clk_chipset);
		#1;
		ioctl_download_i = 1'b0;
		t = 0;
		do begin
			@(negedge clk_chipset);
			t++;
		end while (!bios_protect_o && t < 100);
		if (!bios_protect_o) report_failure("protect did not rise after the download ended");
		if (bios_request_o !== 1'b0) report_mismatch("bios_request_o", 1'b0, bios_request_o);
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		void'($urandom(32'hcd28_b894));
		errors = 0;
		cycle_cnt = 0;
		clk_chipset = 1'b0;
		reset = 1'b1;
		soft_reset_i = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_index_i = 8'd0;
		ioctl_wr_i = 1'b0;
		ioctl_addr_i = '0;
		ioctl_data_i = 8'd0;
		sdram_ready_i = 1'b1;
		bus_idle_i = 1'b1;
		model_tandy_i = ($urandom() & 1) != 0;
		biu_done_i = 1'b0;
		speed_req_i = xt_pkg::SPEED_4M77;
		{clk_4m77_i, clk_7m16_i, clk_14m318_i,
			periph_clk_i, opl2_clk_i, uart_clk_i} = '0;
		slow_lvl = '0;
		for (int i = 0; i < 6; i++) begin
			run_left[i] = 0;
		end
		snd_left = 0;
		opl2_snd_i = '0;
		speaker_i = 1'b1;
		tandy_snd_i = 8'd0;
		repeat (8) @(posedge clk_chipset);
		#1;
		reset = 1'b0;
		measure_reset_release();
		// soft reset pulse repeats the release timing
		@(posedge clk_chipset);
		#1;
		soft_reset_i = 1'b1;
		@(posedge clk_chipset);
		#1;
		soft_reset_i = 1'b0;
		measure_reset_release();
		run_download(8'd0, 1'b1);
		run_download(8'd1, 1'b1);
		run_download(8'd2, 1'b1);
		run_download(8'd3, 1'b1);
		run_download(8'd5, 1'b0);
		repeat (AUDIO_TEST) @(posedge clk_chipset);
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
